//--- hdl/axi_mem_pkg.sv
// AXI memory bridge package with bus widths, AXI channel structs and internal beat structs.
`default_nettype none

package axi_mem_pkg;

  // Bus widths of the AXI slave port.
  localparam int unsigned AxiAddrWidth = 32;
  localparam int unsigned AxiIdWidth   = 4;
  localparam int unsigned AxiDataWidth = 64;
  localparam int unsigned AxiStrbWidth = AxiDataWidth / 8;
  localparam int unsigned AxiLenWidth  = 4;

  // Address channels, INCR bursts of len+1 full-width beats.
  typedef struct packed {
    logic [AxiIdWidth-1:0]   id;
    logic [AxiAddrWidth-1:0] addr;
    logic [AxiLenWidth-1:0]  len;
  } aw_chan_t;

  typedef struct packed {
    logic [AxiIdWidth-1:0]   id;
    logic [AxiAddrWidth-1:0] addr;
    logic [AxiLenWidth-1:0]  len;
  } ar_chan_t;

  typedef struct packed {
    logic [AxiDataWidth-1:0] data;
    logic [AxiStrbWidth-1:0] strb;
    logic                    last;
  } w_chan_t;

  // Response channels, always OKAY so no resp field.
  typedef struct packed {
    logic [AxiIdWidth-1:0] id;
  } b_chan_t;

  typedef struct packed {
    logic [AxiIdWidth-1:0]   id;
    logic [AxiDataWidth-1:0] data;
    logic                    last;
  } r_chan_t;

  // One accepted burst, handed from the arbiter to the burst generator.
  typedef struct packed {
    logic [AxiIdWidth-1:0]   id;
    logic [AxiAddrWidth-1:0] addr;
    logic [AxiLenWidth-1:0]  len;
    logic                    write;
  } burst_cmd_t;

  // One beat; addr is a bank word address, not a byte address.
  typedef struct packed {
    logic [AxiAddrWidth-1:0] addr;
    logic                    write;
    logic [AxiDataWidth-1:0] data;
    logic [AxiStrbWidth-1:0] strb;
    logic [AxiIdWidth-1:0]   id;
    logic                    last;
  } beat_t;

  // Bookkeeping for one beat in flight to the banks.
  typedef struct packed {
    logic [AxiIdWidth-1:0] id;
    logic                  write;
    logic                  last;
  } resp_tag_t;

endpackage

`default_nettype wire

//--- hdl/axi_req_arbiter.sv
// AXI request arbiter, takes AW or AR with read/write alternation and registers one burst.
`timescale 1ns/1ns
`default_nettype none

module axi_req_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  axi_mem_pkg::aw_chan_t   aw_i,
  input  logic                    aw_valid_i,
  output logic                    aw_ready_o,
  input  axi_mem_pkg::ar_chan_t   ar_i,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  output axi_mem_pkg::burst_cmd_t cmd_o,
  output logic                    cmd_valid_o,
  input  logic                    cmd_ready_i
);

  logic                    cmd_valid_q;
  axi_mem_pkg::burst_cmd_t cmd_q;
  // Set when the last granted burst was a write.
  logic                    last_write_q;
  logic                    pick_aw;
  logic                    pick_ar;

  // Writes win unless a read is waiting and the last grant went to a write.
  assign pick_aw = aw_valid_i && (!ar_valid_i || !last_write_q);
  assign pick_ar = ar_valid_i && !pick_aw;

  // Only one command slot, so both channels stall while it is full.
  assign aw_ready_o  = !cmd_valid_q && pick_aw;
  assign ar_ready_o  = !cmd_valid_q && pick_ar;
  assign cmd_o       = cmd_q;
  assign cmd_valid_o = cmd_valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cmd_valid_q  <= 1'b0;
      last_write_q <= 1'b0;
    end else if (cmd_valid_q) begin
      // Slot frees once the burst generator takes the command.
      if (cmd_ready_i) begin
        cmd_valid_q <= 1'b0;
      end
    end else if (pick_aw || pick_ar) begin
      cmd_valid_q  <= 1'b1;
      last_write_q <= pick_aw;
    end
  end

  // Command payload.
  always_ff @(posedge clk_i) begin
    if (!cmd_valid_q) begin
      if (pick_aw) begin
        cmd_q <= '{id: aw_i.id, addr: aw_i.addr, len: aw_i.len, write: 1'b1};
      end else if (pick_ar) begin
        cmd_q <= '{id: ar_i.id, addr: ar_i.addr, len: ar_i.len, write: 1'b0};
      end
    end
  end

  // A waiting AW request keeps its payload until the arbiter takes it.
  a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    aw_valid_i && !aw_ready_o |=> aw_valid_i && $stable(aw_i));

  // Same for a waiting AR request.
  a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ar_valid_i && !ar_ready_o |=> ar_valid_i && $stable(ar_i));

endmodule

`default_nettype wire

//--- hdl/axi_burst_gen.sv
// Burst generator, expands one INCR burst into beats and joins write beats with W data.
`timescale 1ns/1ns
`default_nettype none

module axi_burst_gen #(
  parameter int unsigned BankWords = 256
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  axi_mem_pkg::burst_cmd_t cmd_i,
  input  logic                    cmd_valid_i,
  output logic                    cmd_ready_o,
  input  axi_mem_pkg::w_chan_t    w_i,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  output axi_mem_pkg::beat_t      beat_o,
  output logic                    beat_valid_o,
  input  logic                    beat_ready_i
);

  logic                                        active_q;
  axi_mem_pkg::burst_cmd_t                     cmd_q;
  logic [axi_mem_pkg::AxiLenWidth-1:0]         cnt_q;
  // Byte address of the current beat.
  logic [axi_mem_pkg::AxiAddrWidth-1:0]        addr_q;
  logic                                        beat_fire;

  // New burst only when the previous one is fully issued.
  assign cmd_ready_o = !active_q;

  // Reads stream freely, writes wait for one W beat each.
  assign beat_valid_o = active_q && (!cmd_q.write || w_valid_i);
  assign w_ready_o    = active_q && cmd_q.write && beat_ready_i;
  assign beat_fire    = beat_valid_o && beat_ready_i;

  always_comb begin
    // Beat index into the bank words, upper address bits alias.
    beat_o.addr  = axi_mem_pkg::AxiAddrWidth'((addr_q >> 3) % BankWords);
    beat_o.write = cmd_q.write;
    beat_o.data  = w_i.data;
    // Reads carry no strobe.
    beat_o.strb  = cmd_q.write ? w_i.strb : '0;
    beat_o.id    = cmd_q.id;
    beat_o.last  = (cnt_q == cmd_q.len);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
    end else if (!active_q) begin
      active_q <= cmd_valid_i;
    end else if (beat_fire && beat_o.last) begin
      active_q <= 1'b0;
    end
  end

  // Burst state, loaded while idle and stepped per issued beat.
  always_ff @(posedge clk_i) begin
    if (!active_q) begin
      cmd_q  <= cmd_i;
      addr_q <= cmd_i.addr;
      cnt_q  <= '0;
    end else if (beat_fire) begin
      addr_q <= addr_q + axi_mem_pkg::AxiAddrWidth'(axi_mem_pkg::AxiStrbWidth);
      cnt_q  <= cnt_q + 1'b1;
    end
  end

  // The master's W last lines up with the burst length from AW.
  a_w_last: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    w_valid_i && w_ready_o |-> w_i.last == beat_o.last);

endmodule

`default_nettype wire

//--- hdl/mem_bank_split.sv
// Bank splitter, turns each beat into one request per bank and pushes a response tag.
`timescale 1ns/1ns
`default_nettype none

module mem_bank_split #(
  parameter  int unsigned NumBanks      = 2,
  parameter  int unsigned BankWords     = 256,
  localparam int unsigned LaneWidth     = axi_mem_pkg::AxiDataWidth / NumBanks,
  localparam int unsigned LaneStrb      = axi_mem_pkg::AxiStrbWidth / NumBanks,
  localparam int unsigned BankAddrWidth = $clog2(BankWords)
) (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  axi_mem_pkg::beat_t                           beat_i,
  input  logic                                         beat_valid_i,
  output logic                                         beat_ready_o,
  output axi_mem_pkg::resp_tag_t                       tag_o,
  output logic                                         tag_valid_o,
  input  logic                                         tag_ready_i,
  output logic [NumBanks-1:0]                          mem_req_o,
  input  logic [NumBanks-1:0]                          mem_gnt_i,
  output logic [NumBanks-1:0][BankAddrWidth-1:0]       mem_addr_o,
  output logic [NumBanks-1:0][LaneWidth-1:0]           mem_wdata_o,
  output logic [NumBanks-1:0][LaneStrb-1:0]            mem_strb_o,
  output logic [NumBanks-1:0]                          mem_we_o
);

  logic all_gnt;

  // A beat moves only when every lane is granted and the collector has room.
  assign all_gnt      = &mem_gnt_i;
  assign beat_ready_o = tag_ready_i && all_gnt;
  assign tag_valid_o  = beat_valid_i && all_gnt;
  assign tag_o        = '{id: beat_i.id, write: beat_i.write, last: beat_i.last};

  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      // No request while the tag buffer is full.
      mem_req_o[b]   = beat_valid_i && tag_ready_i;
      // Same word in every bank, lane b holds bytes of slice b.
      mem_addr_o[b]  = beat_i.addr[BankAddrWidth-1:0];
      mem_wdata_o[b] = beat_i.data[b*LaneWidth +: LaneWidth];
      mem_strb_o[b]  = beat_i.strb[b*LaneStrb +: LaneStrb];
      mem_we_o[b]    = beat_i.write;
    end
  end

  // Any bank access that a bank accepts has a tag entering the collector.
  a_tag_with_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    |(mem_req_o & mem_gnt_i) |-> tag_valid_o && tag_ready_i);

endmodule

`default_nettype wire

//--- hdl/mem_resp_collect.sv
// Response collector, pairs tags with bank data and returns R beats and B responses.
`timescale 1ns/1ns
`default_nettype none

module mem_resp_collect #(
  parameter  int unsigned NumBanks  = 2,
  parameter  int unsigned BufDepth  = 4,
  localparam int unsigned LaneWidth = axi_mem_pkg::AxiDataWidth / NumBanks,
  localparam int unsigned PtrWidth  = $clog2(BufDepth)
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  axi_mem_pkg::resp_tag_t             tag_i,
  input  logic                               tag_valid_i,
  output logic                               tag_ready_o,
  input  logic [NumBanks-1:0]                mem_rvalid_i,
  input  logic [NumBanks-1:0][LaneWidth-1:0] mem_rdata_i,
  output axi_mem_pkg::r_chan_t               r_o,
  output logic                               r_valid_o,
  input  logic                               r_ready_i,
  output axi_mem_pkg::b_chan_t               b_o,
  output logic                               b_valid_o,
  input  logic                               b_ready_i,
  output logic                               pending_o
);

  axi_mem_pkg::resp_tag_t                tag_mem_q  [BufDepth];
  logic [axi_mem_pkg::AxiDataWidth-1:0]  data_mem_q [BufDepth];
  logic [PtrWidth-1:0]                   wr_ptr_q;
  logic [PtrWidth-1:0]                   rd_ptr_q;
  logic [PtrWidth:0]                     count_q;
  // Tag of the beat whose bank data arrives this cycle.
  logic                                  pend_q;
  axi_mem_pkg::resp_tag_t                pend_tag_q;
  axi_mem_pkg::resp_tag_t                head;
  logic                                  head_valid;
  logic                                  push;
  logic                                  pop;

  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(BufDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Keep one slot free for the beat still in the banks.
  assign tag_ready_o = count_q < (PtrWidth + 1)'(BufDepth - 1);
  assign push        = pend_q && (&mem_rvalid_i);

  assign head_valid = count_q != '0;
  assign head       = tag_mem_q[rd_ptr_q];

  // Reads leave as R, the last write beat as B, other write beats drop out.
  assign r_valid_o = head_valid && !head.write;
  assign b_valid_o = head_valid && head.write && head.last;
  assign pop       = head_valid && (head.write ? (!head.last || b_ready_i) : r_ready_i);

  assign r_o       = '{id: head.id, data: data_mem_q[rd_ptr_q], last: head.last};
  assign b_o       = '{id: head.id};
  assign pending_o = head_valid || pend_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q   <= 1'b0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      pend_q <= tag_valid_i && tag_ready_o;
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_q + (PtrWidth + 1)'(push) - (PtrWidth + 1)'(pop);
    end
  end

  // Tag and data storage.
  always_ff @(posedge clk_i) begin
    if (tag_valid_i && tag_ready_o) begin
      pend_tag_q <= tag_i;
    end
    if (push) begin
      tag_mem_q[wr_ptr_q]  <= pend_tag_q;
      // Lane 0 is the low slice of the bus word.
      data_mem_q[wr_ptr_q] <= mem_rdata_i;
    end
  end

  // Banks answer only for a request that the splitter issued the cycle before.
  a_rvalid_expected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    |mem_rvalid_i |-> pend_q);

endmodule

`default_nettype wire

//--- hdl/sram_bank.sv
// Single-port SRAM bank with byte write enables and one cycle read latency.
`timescale 1ns/1ns
`default_nettype none

module sram_bank #(
  parameter  int unsigned BankWords = 256,
  parameter  int unsigned DataWidth = 32,
  localparam int unsigned AddrWidth = $clog2(BankWords),
  localparam int unsigned StrbWidth = DataWidth / 8
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_i,
  output logic                 gnt_o,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0] wdata_i,
  input  logic [StrbWidth-1:0] strb_i,
  input  logic                 we_i,
  output logic                 rvalid_o,
  output logic [DataWidth-1:0] rdata_o
);

  logic [DataWidth-1:0] mem_q [BankWords];
  logic                 rvalid_q;

  // Single port with no contention, every request is granted at once.
  assign gnt_o    = req_i;
  assign rvalid_o = rvalid_q;

  // Writes are acknowledged too.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int i = 0; i < StrbWidth; i++) begin
          if (strb_i[i]) begin
            mem_q[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/axi_to_mem_top.sv
// AXI to banked memory top, chains the four bridge stages and the SRAM banks.
`timescale 1ns/1ns
`default_nettype none

module axi_to_mem_top #(
  parameter int unsigned NumBanks  = 2,
  parameter int unsigned BankWords = 256,
  parameter int unsigned BufDepth  = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  output logic                  busy_o,
  input  axi_mem_pkg::aw_chan_t aw_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  axi_mem_pkg::w_chan_t  w_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  output axi_mem_pkg::b_chan_t  b_o,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  input  axi_mem_pkg::ar_chan_t ar_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  output axi_mem_pkg::r_chan_t  r_o,
  output logic                  r_valid_o,
  input  logic                  r_ready_i
);

  localparam int unsigned LaneWidth     = axi_mem_pkg::AxiDataWidth / NumBanks;
  localparam int unsigned LaneStrb      = axi_mem_pkg::AxiStrbWidth / NumBanks;
  localparam int unsigned BankAddrWidth = $clog2(BankWords);

  axi_mem_pkg::burst_cmd_t                   cmd;
  logic                                      cmd_valid;
  logic                                      cmd_ready;
  axi_mem_pkg::beat_t                        beat;
  logic                                      beat_valid;
  logic                                      beat_ready;
  axi_mem_pkg::resp_tag_t                    tag;
  logic                                      tag_valid;
  logic                                      tag_ready;
  logic                                      pending;
  logic [NumBanks-1:0]                       mem_req;
  logic [NumBanks-1:0]                       mem_gnt;
  logic [NumBanks-1:0][BankAddrWidth-1:0]    mem_addr;
  logic [NumBanks-1:0][LaneWidth-1:0]        mem_wdata;
  logic [NumBanks-1:0][LaneStrb-1:0]         mem_strb;
  logic [NumBanks-1:0]                       mem_we;
  logic [NumBanks-1:0]                       mem_rvalid;
  logic [NumBanks-1:0][LaneWidth-1:0]        mem_rdata;

  // A held command, an open burst or any beat in the collector counts as busy.
  assign busy_o = cmd_valid || !cmd_ready || pending;

  axi_req_arbiter u_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .aw_i        (aw_i),
    .aw_valid_i  (aw_valid_i),
    .aw_ready_o  (aw_ready_o),
    .ar_i        (ar_i),
    .ar_valid_i  (ar_valid_i),
    .ar_ready_o  (ar_ready_o),
    .cmd_o       (cmd),
    .cmd_valid_o (cmd_valid),
    .cmd_ready_i (cmd_ready)
  );

  axi_burst_gen #(.BankWords(BankWords)) u_burst_gen (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cmd_i        (cmd),
    .cmd_valid_i  (cmd_valid),
    .cmd_ready_o  (cmd_ready),
    .w_i          (w_i),
    .w_valid_i    (w_valid_i),
    .w_ready_o    (w_ready_o),
    .beat_o       (beat),
    .beat_valid_o (beat_valid),
    .beat_ready_i (beat_ready)
  );

  mem_bank_split #(.NumBanks(NumBanks), .BankWords(BankWords)) u_split (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .beat_i       (beat),
    .beat_valid_i (beat_valid),
    .beat_ready_o (beat_ready),
    .tag_o        (tag),
    .tag_valid_o  (tag_valid),
    .tag_ready_i  (tag_ready),
    .mem_req_o    (mem_req),
    .mem_gnt_i    (mem_gnt),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_strb_o   (mem_strb),
    .mem_we_o     (mem_we)
  );

  mem_resp_collect #(.NumBanks(NumBanks), .BufDepth(BufDepth)) u_collect (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .tag_i        (tag),
    .tag_valid_i  (tag_valid),
    .tag_ready_o  (tag_ready),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata),
    .r_o          (r_o),
    .r_valid_o    (r_valid_o),
    .r_ready_i    (r_ready_i),
    .b_o          (b_o),
    .b_valid_o    (b_valid_o),
    .b_ready_i    (b_ready_i),
    .pending_o    (pending)
  );

  // One bank per data lane.
  for (genvar g = 0; g < NumBanks; g++) begin : g_bank
    sram_bank #(.BankWords(BankWords), .DataWidth(LaneWidth)) u_bank (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .req_i    (mem_req[g]),
      .gnt_o    (mem_gnt[g]),
      .addr_i   (mem_addr[g]),
      .wdata_i  (mem_wdata[g]),
      .strb_i   (mem_strb[g]),
      .we_i     (mem_we[g]),
      .rvalid_o (mem_rvalid[g]),
      .rdata_o  (mem_rdata[g])
    );
  end

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
// Testbench clock and reset generator, 40 ns clock with a synchronous active low reset.
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned HalfPeriod  = 20,
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    // Release just after an edge, in step with the other inputs.
    #2;
    rst_n_o = 1'b1;
  end

  always #HalfPeriod clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- dv/axi_mem_checker.sv
// AXI monitor and scoreboard, keeps a memory model and compares every R beat and B response.
`timescale 1ns/1ns
`default_nettype none

module axi_mem_checker #(
  parameter int unsigned BankWords = 256
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  busy_i,
  input  axi_mem_pkg::aw_chan_t aw_i,
  input  logic                  aw_valid_i,
  input  logic                  aw_ready_i,
  input  axi_mem_pkg::w_chan_t  w_i,
  input  logic                  w_valid_i,
  input  logic                  w_ready_i,
  input  axi_mem_pkg::b_chan_t  b_i,
  input  logic                  b_valid_i,
  input  logic                  b_ready_i,
  input  axi_mem_pkg::ar_chan_t ar_i,
  input  logic                  ar_valid_i,
  input  logic                  ar_ready_i,
  input  axi_mem_pkg::r_chan_t  r_i,
  input  logic                  r_valid_i,
  input  logic                  r_ready_i,
  output int                    errors_o,
  output int                    outstanding_o
);

  // Reference memory, one 64-bit word per bank word index.
  logic [63:0]           model_q [BankWords];
  // Write bursts whose W beats are still arriving.
  axi_mem_pkg::aw_chan_t aw_q [$];
  axi_mem_pkg::r_chan_t  exp_r_q [$];
  logic [3:0]            exp_b_q [$];
  int                    w_beat = 0;
  int                    errors = 0;

  // Byte address steps by 8 per beat, upper bits alias onto the bank words.
  function automatic int word_index(input logic [31:0] addr, input int beat);
    return int'(((addr + 32'(8 * beat)) >> 3) % BankWords);
  endfunction

  task automatic report_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
    errors++;
  endtask

  // Sampled mid-cycle, where both DUT outputs and driven inputs are settled.
  always @(negedge clk_i) begin
    axi_mem_pkg::aw_chan_t cur_aw;
    axi_mem_pkg::r_chan_t  exp_r;
    logic [3:0]            exp_b;
    int                    idx;
    if (rst_n_i) begin
      // An accepted burst still owed a response keeps the bridge busy.
      if (exp_r_q.size() + exp_b_q.size() != 0 && busy_i !== 1'b1) begin
        report_value("busy_o", 64'd1, 64'(busy_i));
      end
      if (aw_valid_i && aw_ready_i) begin
        aw_q.push_back(aw_i);
        exp_b_q.push_back(aw_i.id);
      end
      if (w_valid_i && w_ready_i) begin
        if (aw_q.size() == 0) begin
          $display("%0t W beat accepted with no write burst open", $time);
          errors++;
        end else begin
          cur_aw = aw_q[0];
          idx    = word_index(cur_aw.addr, w_beat);
          for (int k = 0; k < 8; k++) begin
            if (w_i.strb[k]) begin
              model_q[idx][k*8 +: 8] = w_i.data[k*8 +: 8];
            end
          end
          if (w_beat == int'(cur_aw.len)) begin
            void'(aw_q.pop_front());
            w_beat = 0;
          end else begin
            w_beat++;
          end
        end
      end
      // Read data is taken from the model as it stands at the AR handshake.
      if (ar_valid_i && ar_ready_i) begin
        for (int i = 0; i <= int'(ar_i.len); i++) begin
          exp_r.id   = ar_i.id;
          exp_r.data = model_q[word_index(ar_i.addr, i)];
          exp_r.last = (i == int'(ar_i.len));
          exp_r_q.push_back(exp_r);
        end
      end
      if (r_valid_i && r_ready_i) begin
        if (exp_r_q.size() == 0) begin
          $display("%0t R beat returned with no read outstanding", $time);
          errors++;
        end else begin
          exp_r = exp_r_q.pop_front();
          if (r_i.data !== exp_r.data) report_value("r_o.data", exp_r.data, r_i.data);
          if (r_i.id !== exp_r.id) report_value("r_o.id", 64'(exp_r.id), 64'(r_i.id));
          if (r_i.last !== exp_r.last) report_value("r_o.last", 64'(exp_r.last), 64'(r_i.last));
        end
      end
      if (b_valid_i && b_ready_i) begin
        if (exp_b_q.size() == 0) begin
          $display("%0t B response returned with no write outstanding", $time);
          errors++;
        end else begin
          exp_b = exp_b_q.pop_front();
          if (b_i.id !== exp_b) report_value("b_o.id", 64'(exp_b), 64'(b_i.id));
        end
      end
    end
    errors_o      <= errors;
    outstanding_o <= exp_r_q.size() + exp_b_q.size();
  end

endmodule

`default_nettype wire

//--- dv/axi_mem_tb.sv
// Testbench top for the AXI to banked memory bridge, random bursts from a fixed seed.
`timescale 1ns/1ns
`default_nettype none

module axi_mem_tb;

  localparam int unsigned NumBanks   = 2;
  localparam int unsigned BankWords  = 256;
  localparam int unsigned BufDepth   = 4;
  localparam int unsigned HalfWords  = BankWords / 2 - 16;
  localparam int unsigned DriveDelay = 2;
  localparam int unsigned NumBursts  = 20;
  localparam int unsigned NumPairs   = 8;
  localparam int unsigned NumStall   = 50;
  // Reset pair, fill, bursts, strobes, concurrent pairs, back-pressure, aliasing.
  localparam int unsigned NumTxn = 2 + BankWords / 16 + 4 * NumBursts + 2 * NumPairs
                                   + NumStall + 4;
  // At most 16 beats per transaction.
  localparam int unsigned TimeoutCycles = NumTxn * 16 * 20 + 1000;

  logic                  clk;
  logic                  rst_n;
  logic                  busy;
  axi_mem_pkg::aw_chan_t aw;
  logic                  aw_valid;
  logic                  aw_ready;
  axi_mem_pkg::w_chan_t  w;
  logic                  w_valid;
  logic                  w_ready;
  axi_mem_pkg::b_chan_t  b;
  logic                  b_valid;
  logic                  b_ready;
  axi_mem_pkg::ar_chan_t ar;
  logic                  ar_valid;
  logic                  ar_ready;
  axi_mem_pkg::r_chan_t  r;
  logic                  r_valid;
  logic                  r_ready;
  integer                seed = 32443;
  int                    chk_errors;
  int                    outstanding;
  int                    tb_errors = 0;
  int                    errs_before = 0;
  int                    passed = 0;
  int                    failed = 0;
  int unsigned           cycles = 0;
  logic                  stall_on;

  tb_clk_gen #(.HalfPeriod(20), .ResetCycles(16)) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  axi_to_mem_top #(.NumBanks(NumBanks), .BankWords(BankWords), .BufDepth(BufDepth)) DUT (
    .clk_i (clk), .rst_n_i (rst_n), .busy_o (busy),
    .aw_i (aw), .aw_valid_i (aw_valid), .aw_ready_o (aw_ready),
    .w_i (w), .w_valid_i (w_valid), .w_ready_o (w_ready),
    .b_o (b), .b_valid_o (b_valid), .b_ready_i (b_ready),
    .ar_i (ar), .ar_valid_i (ar_valid), .ar_ready_o (ar_ready),
    .r_o (r), .r_valid_o (r_valid), .r_ready_i (r_ready)
  );

  axi_mem_checker #(.BankWords(BankWords)) u_checker (
    .clk_i (clk), .rst_n_i (rst_n), .busy_i (busy),
    .aw_i (aw), .aw_valid_i (aw_valid), .aw_ready_i (aw_ready),
    .w_i (w), .w_valid_i (w_valid), .w_ready_i (w_ready),
    .b_i (b), .b_valid_i (b_valid), .b_ready_i (b_ready),
    .ar_i (ar), .ar_valid_i (ar_valid), .ar_ready_i (ar_ready),
    .r_i (r), .r_valid_i (r_valid), .r_ready_i (r_ready),
    .errors_o (chk_errors), .outstanding_o (outstanding)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout after %0d cycles with %0d responses outstanding", cycles, outstanding);
      $display("TEST FAIL");
      $finish;
    end
  end

  // Response ready, randomly withheld while stalling is on.
  always @(posedge clk) begin
    logic [31:0] rnd;
    #DriveDelay;
    rnd     = $random(seed);
    r_ready = !stall_on || rnd[0];
    b_ready = !stall_on || rnd[1];
  end

  function automatic logic [31:0] rand_u32();
    return $random(seed);
  endfunction

  // Aligned byte address of a random bank word.
  function automatic logic [31:0] rand_addr();
    return (rand_u32() % BankWords) << 3;
  endfunction

  // Both halves depend on every address bit.
  function automatic logic [63:0] fill_word(input logic [31:0] addr);
    return {addr ^ 32'h5a3c_96e1, ~addr};
  endfunction

  task automatic expect_low(input string name, input logic value);
    if (value !== 1'b0) begin
      $display("[ERROR] %0t %s expected 0 actual %b", $time, name, value);
      tb_errors++;
    end
  endtask

  task automatic send_aw(input logic [31:0] baddr, input logic [3:0] blen, input logic [3:0] bid);
    aw.id    = bid;
    aw.addr  = baddr;
    aw.len   = blen;
    aw_valid = 1'b1;
    do @(negedge clk); while (!aw_ready);
    @(posedge clk);
    #DriveDelay;
    aw_valid = 1'b0;
  endtask

  task automatic send_w(input logic [31:0] baddr, input logic [3:0] blen, input logic rand_strb,
                        input logic fill);
    logic [31:0] rnd;
    for (int i = 0; i <= int'(blen); i++) begin
      rnd     = rand_u32();
      w.data  = fill ? fill_word(baddr + 32'(8 * i)) : {rand_u32(), rand_u32()};
      w.strb  = rand_strb ? rnd[7:0] : 8'hff;
      w.last  = (i == int'(blen));
      w_valid = 1'b1;
      do @(negedge clk); while (!w_ready);
      @(posedge clk);
      #DriveDelay;
    end
    w_valid = 1'b0;
  endtask

  task automatic write_burst(input logic [31:0] baddr, input logic [3:0] blen,
                             input logic [3:0] bid, input logic rand_strb, input logic fill);
    fork
      send_aw(baddr, blen, bid);
      send_w(baddr, blen, rand_strb, fill);
    join
  endtask

  task automatic read_burst(input logic [31:0] baddr, input logic [3:0] blen, input logic [3:0] bid);
    ar.id    = bid;
    ar.addr  = baddr;
    ar.len   = blen;
    ar_valid = 1'b1;
    do @(negedge clk); while (!ar_ready);
    @(posedge clk);
    #DriveDelay;
    ar_valid = 1'b0;
  endtask

  // Every expected response taken and the bridge idle again.
  task automatic wait_idle();
    do @(negedge clk); while (outstanding != 0 || busy);
    @(posedge clk);
    #DriveDelay;
  endtask

  task automatic end_test(input string name);
    if (tb_errors + chk_errors == errs_before) begin
      passed++;
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: failed", name);
    end
    errs_before = tb_errors + chk_errors;
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] addr;
    logic [31:0] raddr;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    b_ready  = 1'b0;
    stall_on = 1'b0;
    @(posedge rst_n);
    @(negedge clk);
    expect_low("aw_ready_o", aw_ready);
    expect_low("w_ready_o", w_ready);
    expect_low("ar_ready_o", ar_ready);
    expect_low("b_valid_o", b_valid);
    expect_low("r_valid_o", r_valid);
    expect_low("busy_o", busy);
    @(posedge clk);
    #DriveDelay;
    // Single beat written and read back under the same ID.
    rnd  = rand_u32();
    addr = rand_addr();
    write_burst(addr, 4'd0, rnd[3:0], 1'b0, 1'b0);
    wait_idle();
    read_burst(addr, 4'd0, rnd[3:0]);
    wait_idle();
    end_test("reset");

    // Whole memory filled first, so no later read sees an unwritten word.
    for (int i = 0; i < int'(BankWords / 16); i++) begin
      write_burst(32'(i * 128), 4'd15, 4'(i), 1'b0, 1'b1);
      wait_idle();
    end
    for (int i = 0; i < int'(NumBursts); i++) begin
      rnd  = rand_u32();
      addr = rand_addr();
      write_burst(addr, rnd[3:0], rnd[7:4], 1'b0, 1'b0);
      wait_idle();
      read_burst(addr, rnd[3:0], rnd[11:8]);
      wait_idle();
    end
    end_test("bursts");

    for (int i = 0; i < int'(NumBursts); i++) begin
      rnd  = rand_u32();
      addr = rand_addr();
      write_burst(addr, rnd[3:0], rnd[7:4], 1'b1, 1'b0);
      wait_idle();
      read_burst(addr, rnd[3:0], rnd[11:8]);
      wait_idle();
    end
    end_test("strobes");

    // Writes in the lower half, reads in the upper half.
    for (int i = 0; i < int'(NumPairs); i++) begin
      rnd   = rand_u32();
      addr  = (rand_u32() % HalfWords) << 3;
      raddr = (BankWords / 2 + rand_u32() % HalfWords) << 3;
      fork
        write_burst(addr, rnd[3:0], rnd[7:4], 1'b1, 1'b0);
        read_burst(raddr, rnd[11:8], rnd[15:12]);
      join
      wait_idle();
    end
    end_test("concurrency");

    stall_on = 1'b1;
    for (int i = 0; i < int'(NumStall); i++) begin
      rnd  = rand_u32();
      addr = rand_addr();
      if (rnd[16]) begin
        write_burst(addr, rnd[3:0], rnd[7:4], rnd[17], 1'b0);
      end else begin
        read_burst(addr, rnd[3:0], rnd[7:4]);
      end
      wait_idle();
    end
    stall_on = 1'b0;
    end_test("backpressure");

    // High address written and read low, then the other way round.
    rnd  = rand_u32();
    addr = rand_addr();
    write_burst(addr + 32'(4096 * (1 + rnd[2:0])), rnd[7:4], rnd[11:8], 1'b0, 1'b0);
    wait_idle();
    read_burst(addr, rnd[7:4], rnd[15:12]);
    wait_idle();
    rnd  = rand_u32();
    addr = rand_addr();
    write_burst(addr, rnd[7:4], rnd[11:8], 1'b1, 1'b0);
    wait_idle();
    read_burst(addr + 32'(4096 * (2 + rnd[2:0])), rnd[7:4], rnd[15:12]);
    wait_idle();
    end_test("aliasing");

    $display("tests passed %0d failed %0d, errors %0d", passed, failed, tb_errors + chk_errors);
    if (failed == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
hdl/axi_mem_pkg.sv
hdl/axi_req_arbiter.sv
hdl/axi_burst_gen.sv
hdl/mem_bank_split.sv
hdl/mem_resp_collect.sv
hdl/sram_bank.sv
hdl/axi_to_mem_top.sv
dv/tb_clk_gen.sv
dv/axi_mem_checker.sv
dv/axi_mem_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run; pass only when the simulation prints the pass line.
verilator --binary --timing --assert -j 0 -f all.f --top-module axi_mem_tb -o axi_mem_sim \
  && ./obj_dir/axi_mem_sim | tee /dev/stderr | grep -qx "TEST PASS" \
  || { echo "simulation failed"; exit 1; }
